//--- usb_txn_macros.svh
`ifndef USB_TXN_MACROS_SVH
`define USB_TXN_MACROS_SVH

// Bus field widths
`define USB_ADDR_W 7
`define USB_ENDP_W 4
`define MUX_SEL_W 3

// Bulk endpoint numbers, EP1 is OUT and EP2 is IN
`define BULK_OUT_EP 4'd1
`define BULK_IN_EP 4'd2

// Timer limits in clock cycles
`define TA_TIMEOUT 101
`define EP_TIMEOUT 23
`define TD_TIMEOUT 23

// Receive-event code for start of packet
`define RX_EVENT_SOP 2'b01

`endif

//--- usb_txn_pkg.sv
package usb_txn_pkg;

  // PID field as seen by the transaction layer, check nibble already removed
  // Bit 3 of a DATAx PID carries the sequence bit
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110,
    PID_PING  = 4'b0100
  } usb_pid_t;

  // One-hot transaction states
  typedef enum logic [5:0] {
    ST_IDLE = 6'b000001,
    // Receive DATAx after OUT or SETUP
    ST_RECV = 6'b000010,
    // Handshake to the host
    ST_RESP = 6'b000100,
    // Wait for EOP and stay silent
    ST_DROP = 6'b001000,
    // Endpoint data routed to the encoder
    ST_SEND = 6'b010000,
    // Wait for the host handshake
    ST_WAIT = 6'b100000
  } txn_state_t;

  // Counters for the bus timers
  typedef logic [6:0] ta_count_t;
  typedef logic [4:0] short_count_t;

endpackage

//--- endpoint_ctrl.sv
`timescale 1ns/10ps
`include "usb_txn_macros.svh"

module endpoint_ctrl (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    set_conf_i,
  input  logic                    clr_conf_i,
  input  logic                    tok_recv_i,
  input  logic [`USB_ADDR_W-1:0]  tok_addr_i,
  input  logic [`USB_ENDP_W-1:0]  tok_endp_i,
  input  logic [`USB_ADDR_W-1:0]  usb_addr_i,
  input  usb_txn_pkg::usb_pid_t   data_pid_i,
  input  logic                    hsk_recv_i,
  input  logic                    hsk_sent_i,
  input  logic                    timeout_i,
  input  logic                    ep0_parity_i,
  input  logic                    ep1_rx_rdy_i,
  input  logic                    ep1_parity_i,
  input  logic                    ep1_halted_i,
  input  logic                    ep2_tx_rdy_i,
  input  logic                    ep2_parity_i,
  input  logic                    ep2_halted_i,
  output logic                    out_sel_o,
  output logic                    out_rdy_o,
  output logic                    in_sel_o,
  output logic                    in_rdy_o,
  output logic                    par_ok_o,
  output usb_txn_pkg::usb_pid_t   data_pid_o,
  output logic                    ep1_select_o,
  output logic                    ep1_finish_o,
  output logic                    ep2_select_o,
  output logic                    ep2_finish_o
);

  logic ep1_en_q;
  logic ep2_en_q;
  logic end_q;
  logic ep0_sel_q;
  logic ep1_sel_q;
  logic ep2_sel_q;
  logic ep1_fin_q;
  logic ep2_fin_q;
  logic tok_hit_w;
  logic ep0_tok_w;
  logic ep1_tok_w;
  logic ep2_tok_w;
  logic seq_w;

  assign tok_hit_w = tok_recv_i && (tok_addr_i == usb_addr_i);
  assign ep0_tok_w = (tok_endp_i == '0);
  assign ep1_tok_w = ep1_en_q && (tok_endp_i == `BULK_OUT_EP);
  assign ep2_tok_w = ep2_en_q && (tok_endp_i == `BULK_IN_EP);

  // A halted endpoint loses its enable until the next set-configuration
  always_ff @(posedge clock) begin
    if (reset || clr_conf_i || ep1_halted_i) begin
      ep1_en_q <= 1'b0;
    end else if (set_conf_i) begin
      ep1_en_q <= 1'b1;
    end
    if (reset || clr_conf_i || ep2_halted_i) begin
      ep2_en_q <= 1'b0;
    end else if (set_conf_i) begin
      ep2_en_q <= 1'b1;
    end
  end

  // End of transaction, a cycle late so the finish pulse still sees its select
  always_ff @(posedge clock) begin
    end_q <= reset || clr_conf_i || hsk_recv_i || hsk_sent_i || timeout_i;
  end

  always_ff @(posedge clock) begin
    if (reset || end_q) begin
      ep0_sel_q <= 1'b0;
      ep1_sel_q <= 1'b0;
      ep2_sel_q <= 1'b0;
    end else if (tok_hit_w) begin
      ep0_sel_q <= ep0_tok_w;
      ep1_sel_q <= ep1_tok_w;
      ep2_sel_q <= ep2_tok_w;
    end
  end

  // OUT endpoint finishes on our handshake, IN endpoint on the host's
  always_ff @(posedge clock) begin
    if (reset || end_q) begin
      ep1_fin_q <= 1'b0;
      ep2_fin_q <= 1'b0;
    end else begin
      ep1_fin_q <= ep1_sel_q && hsk_sent_i;
      ep2_fin_q <= ep2_sel_q && hsk_recv_i;
    end
  end

  assign out_sel_o = ep1_tok_w;
  assign out_rdy_o = ep1_tok_w && ep1_rx_rdy_i && !ep1_halted_i;
  assign in_sel_o  = ep2_tok_w;
  assign in_rdy_o  = ep2_tok_w && ep2_tx_rdy_i && !ep2_halted_i;

  // Sequence bit of the received DATAx against the selected endpoint
  assign par_ok_o = (ep0_sel_q && (ep0_parity_i == data_pid_i[3])) ||
                    (ep1_sel_q && (ep1_parity_i == data_pid_i[3]));

  always_comb begin
    case (tok_endp_i)
      `BULK_OUT_EP: seq_w = ep1_parity_i;
      `BULK_IN_EP:  seq_w = ep2_parity_i;
      default:      seq_w = ep0_parity_i;
    endcase
  end

  assign data_pid_o = seq_w ? usb_txn_pkg::PID_DATA1 : usb_txn_pkg::PID_DATA0;

  assign ep1_select_o = ep1_sel_q;
  assign ep1_finish_o = ep1_fin_q;
  assign ep2_select_o = ep2_sel_q;
  assign ep2_finish_o = ep2_fin_q;

  a_single_select: assert property (@(posedge clock) disable iff (reset)
    $onehot0({ep0_sel_q, ep1_sel_q, ep2_sel_q}))
    else $error("more than one endpoint selected");

endmodule

//--- transaction_fsm.sv
`timescale 1ns/10ps
`include "usb_txn_macros.svh"

module transaction_fsm (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     tok_recv_i,
  input  logic [`USB_ADDR_W-1:0]   tok_addr_i,
  input  logic [`USB_ENDP_W-1:0]   tok_endp_i,
  input  logic [`USB_ADDR_W-1:0]   usb_addr_i,
  input  usb_txn_pkg::usb_pid_t    usb_pid_i,
  input  logic                     usb_recv_i,
  input  logic                     eop_recv_i,
  input  logic                     crc_error_i,
  input  logic                     hsk_sent_i,
  input  logic                     hsk_recv_i,
  input  logic                     usb_sent_i,
  input  logic                     timeout_i,
  input  logic                     out_sel_i,
  input  logic                     out_rdy_i,
  input  logic                     in_sel_i,
  input  logic                     in_rdy_i,
  input  logic                     par_ok_i,
  input  usb_txn_pkg::usb_pid_t    data_pid_i,
  output usb_txn_pkg::txn_state_t  state_o,
  output logic                     tok_hit_o,
  output logic                     hsk_send_o,
  output usb_txn_pkg::usb_pid_t    ulpi_tuser_o,
  output logic                     mux_enable_o,
  output logic [`MUX_SEL_W-1:0]    mux_select_o
);

  usb_txn_pkg::txn_state_t state_q;
  usb_txn_pkg::txn_state_t state_d;
  usb_txn_pkg::usb_pid_t   pid_q;
  usb_txn_pkg::usb_pid_t   pid_d;
  logic                    hsk_q;
  logic                    mux_q;
  logic [`MUX_SEL_W-1:0]   sel_q;
  logic                    ep0_w;

  assign tok_hit_o = tok_recv_i && (tok_addr_i == usb_addr_i);
  assign ep0_w     = (tok_endp_i == '0);

  always_comb begin
    state_d = state_q;
    pid_d   = pid_q;
    case (state_q)
      usb_txn_pkg::ST_IDLE: begin
        if (tok_hit_o) begin
          case (usb_pid_i)
            usb_txn_pkg::PID_SETUP: begin
              if (ep0_w) begin
                state_d = usb_txn_pkg::ST_RECV;
              end else begin
                state_d = usb_txn_pkg::ST_DROP;
                pid_d   = usb_txn_pkg::PID_STALL;
              end
            end
            usb_txn_pkg::PID_OUT: begin
              if (ep0_w || out_rdy_i) begin
                state_d = usb_txn_pkg::ST_RECV;
              end else begin
                state_d = usb_txn_pkg::ST_DROP;
                pid_d   = out_sel_i ? usb_txn_pkg::PID_NAK : usb_txn_pkg::PID_STALL;
              end
            end
            usb_txn_pkg::PID_IN: begin
              pid_d = data_pid_i;
              if (ep0_w || in_rdy_i) begin
                state_d = usb_txn_pkg::ST_SEND;
              end else if (in_sel_i) begin
                state_d = usb_txn_pkg::ST_RESP;
                pid_d   = usb_txn_pkg::PID_NAK;
              end else begin
                // Unsupported, the endpoint timer ends it
                state_d = usb_txn_pkg::ST_WAIT;
              end
            end
            usb_txn_pkg::PID_PING: begin
              state_d = usb_txn_pkg::ST_RESP;
              if (ep0_w || out_rdy_i) begin
                pid_d = usb_txn_pkg::PID_ACK;
              end else begin
                pid_d = out_sel_i ? usb_txn_pkg::PID_NAK : usb_txn_pkg::PID_STALL;
              end
            end
            default: state_d = usb_txn_pkg::ST_IDLE;
          endcase
        end
      end
      usb_txn_pkg::ST_RECV: begin
        // Sequence error drops the packet silently and the host retries
        if (usb_recv_i) begin
          state_d = par_ok_i ? usb_txn_pkg::ST_RESP : usb_txn_pkg::ST_IDLE;
          pid_d   = usb_txn_pkg::PID_ACK;
        end else if (timeout_i || crc_error_i) begin
          state_d = usb_txn_pkg::ST_IDLE;
        end
      end
      usb_txn_pkg::ST_RESP: begin
        if (hsk_sent_i || timeout_i) begin
          state_d = usb_txn_pkg::ST_IDLE;
        end
      end
      usb_txn_pkg::ST_SEND: begin
        if (usb_sent_i) begin
          state_d = usb_txn_pkg::ST_WAIT;
        end else if (timeout_i) begin
          state_d = usb_txn_pkg::ST_IDLE;
        end
      end
      usb_txn_pkg::ST_WAIT: begin
        if (hsk_recv_i || timeout_i) begin
          state_d = usb_txn_pkg::ST_IDLE;
        end
      end
      usb_txn_pkg::ST_DROP: begin
        if (eop_recv_i || timeout_i) begin
          state_d = usb_txn_pkg::ST_IDLE;
        end
      end
      default: state_d = usb_txn_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= usb_txn_pkg::ST_IDLE;
      hsk_q   <= 1'b0;
      mux_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // Handshake requested for the whole stay in the respond state
      hsk_q   <= (state_d == usb_txn_pkg::ST_RESP);
      mux_q   <= (state_q == usb_txn_pkg::ST_SEND) || (state_q == usb_txn_pkg::ST_WAIT);
    end
  end

  always_ff @(posedge clock) begin
    pid_q <= pid_d;
    case (tok_endp_i)
      '0:           sel_q <= `MUX_SEL_W'd0;
      `BULK_OUT_EP: sel_q <= `MUX_SEL_W'd1;
      `BULK_IN_EP:  sel_q <= `MUX_SEL_W'd2;
      default:      sel_q <= '1;
    endcase
  end

  assign state_o      = state_q;
  assign hsk_send_o   = hsk_q;
  assign ulpi_tuser_o = pid_q;
  assign mux_enable_o = mux_q;
  assign mux_select_o = sel_q;

  a_state_onehot: assert property (@(posedge clock) disable iff (reset) $onehot(state_q))
    else $error("transaction state not one-hot");

endmodule

//--- response_timer.sv
`timescale 1ns/10ps

module response_timer #(
  parameter type count_t = logic [7:0],
  parameter int  limit   = 1
) (
  input  logic clock,
  input  logic reset,
  input  logic start_i,
  input  logic arm_i,
  input  logic stop_i,
  output logic running_o,
  output logic expired_o
);

  count_t count_q;
  logic   run_q;
  logic   err_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      run_q <= 1'b0;
      err_q <= 1'b0;
    end else if (start_i) begin
      run_q <= arm_i;
      err_q <= 1'b0;
    end else if (run_q && (stop_i || count_q == '0)) begin
      // Expired only when the count ran out without a stop
      run_q <= 1'b0;
      err_q <= !stop_i;
    end else begin
      err_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (start_i) begin
      count_q <= count_t'(limit);
    end else if (run_q) begin
      count_q <= count_t'(count_q - 1'b1);
    end
  end

  assign running_o = run_q;
  assign expired_o = err_q;

endmodule

//--- bus_timeouts.sv
`timescale 1ns/10ps
`include "usb_txn_macros.svh"

module bus_timeouts (
  input  logic                     clock,
  input  logic                     reset,
  input  usb_txn_pkg::txn_state_t  state_i,
  input  logic                     tok_hit_i,
  input  usb_txn_pkg::usb_pid_t    usb_pid_i,
  input  logic                     usb_sent_i,
  input  logic                     usb_busy_i,
  input  logic                     hsk_recv_i,
  input  logic [1:0]               rx_event_i,
  output logic                     timeout_o
);

  logic tok_start_w;
  logic ta_start_w;
  logic ta_exp;
  logic ep_exp;
  logic td_exp;
  logic timeout_q;

  // Both token timers restart on every token and only one gets armed
  assign tok_start_w = tok_hit_i && (state_i == usb_txn_pkg::ST_IDLE);
  assign ta_start_w  = usb_sent_i && (state_i == usb_txn_pkg::ST_SEND);

  // Host handshake due after our DATAx
  response_timer #(.count_t(usb_txn_pkg::ta_count_t), .limit(`TA_TIMEOUT)) ta_timer_i (
    .clock     (clock),
    .reset     (reset),
    .start_i   (ta_start_w),
    .arm_i     (1'b1),
    .stop_i    (hsk_recv_i),
    .running_o (),
    .expired_o (ta_exp)
  );

  // Endpoint must start its DATAx after IN
  response_timer #(.count_t(usb_txn_pkg::short_count_t), .limit(`EP_TIMEOUT)) ep_timer_i (
    .clock     (clock),
    .reset     (reset),
    .start_i   (tok_start_w),
    .arm_i     (usb_pid_i == usb_txn_pkg::PID_IN),
    .stop_i    (usb_busy_i),
    .running_o (),
    .expired_o (ep_exp)
  );

  // Host DATAx due after OUT or SETUP
  response_timer #(.count_t(usb_txn_pkg::short_count_t), .limit(`TD_TIMEOUT)) td_timer_i (
    .clock     (clock),
    .reset     (reset),
    .start_i   (tok_start_w),
    .arm_i     ((usb_pid_i == usb_txn_pkg::PID_OUT) || (usb_pid_i == usb_txn_pkg::PID_SETUP)),
    .stop_i    (rx_event_i == `RX_EVENT_SOP),
    .running_o (),
    .expired_o (td_exp)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      timeout_q <= 1'b0;
    end else begin
      timeout_q <= ta_exp || ep_exp || td_exp;
    end
  end

  assign timeout_o = timeout_q;

  a_timeout_pulse: assert property (@(posedge clock) disable iff (reset)
    timeout_q |=> !timeout_q)
    else $error("timeout longer than one cycle");

endmodule

//--- usb_transaction.sv
`timescale 1ns/10ps
`include "usb_txn_macros.svh"

module usb_transaction (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     tok_recv_i,
  input  logic [`USB_ADDR_W-1:0]   tok_addr_i,
  input  logic [`USB_ENDP_W-1:0]   tok_endp_i,
  input  usb_txn_pkg::usb_pid_t    usb_pid_i,
  input  logic                     usb_recv_i,
  input  logic                     eop_recv_i,
  input  logic                     crc_error_i,
  input  logic [1:0]               rx_event_i,
  input  logic                     hsk_recv_i,
  input  logic                     hsk_sent_i,
  input  logic                     usb_busy_i,
  input  logic                     usb_sent_i,
  input  logic                     set_conf_i,
  input  logic                     clr_conf_i,
  input  logic [`USB_ADDR_W-1:0]   usb_addr_i,
  input  logic                     ep0_parity_i,
  input  logic                     ep1_rx_rdy_i,
  input  logic                     ep1_parity_i,
  input  logic                     ep1_halted_i,
  input  logic                     ep2_tx_rdy_i,
  input  logic                     ep2_parity_i,
  input  logic                     ep2_halted_i,
  output logic                     timedout_o,
  output logic                     hsk_send_o,
  output logic                     mux_enable_o,
  output logic [`MUX_SEL_W-1:0]    mux_select_o,
  output usb_txn_pkg::usb_pid_t    ulpi_tuser_o,
  output logic                     ep1_select_o,
  output logic                     ep1_finish_o,
  output logic                     ep2_select_o,
  output logic                     ep2_finish_o
);

  logic                    out_sel;
  logic                    out_rdy;
  logic                    in_sel;
  logic                    in_rdy;
  logic                    par_ok;
  usb_txn_pkg::usb_pid_t   data_pid;
  usb_txn_pkg::txn_state_t state;
  logic                    tok_hit;
  logic                    timeout;

  endpoint_ctrl endpoint_ctrl_i (
    .clock        (clock),
    .reset        (reset),
    .set_conf_i   (set_conf_i),
    .clr_conf_i   (clr_conf_i),
    .tok_recv_i   (tok_recv_i),
    .tok_addr_i   (tok_addr_i),
    .tok_endp_i   (tok_endp_i),
    .usb_addr_i   (usb_addr_i),
    .data_pid_i   (usb_pid_i),
    .hsk_recv_i   (hsk_recv_i),
    .hsk_sent_i   (hsk_sent_i),
    .timeout_i    (timeout),
    .ep0_parity_i (ep0_parity_i),
    .ep1_rx_rdy_i (ep1_rx_rdy_i),
    .ep1_parity_i (ep1_parity_i),
    .ep1_halted_i (ep1_halted_i),
    .ep2_tx_rdy_i (ep2_tx_rdy_i),
    .ep2_parity_i (ep2_parity_i),
    .ep2_halted_i (ep2_halted_i),
    .out_sel_o    (out_sel),
    .out_rdy_o    (out_rdy),
    .in_sel_o     (in_sel),
    .in_rdy_o     (in_rdy),
    .par_ok_o     (par_ok),
    .data_pid_o   (data_pid),
    .ep1_select_o (ep1_select_o),
    .ep1_finish_o (ep1_finish_o),
    .ep2_select_o (ep2_select_o),
    .ep2_finish_o (ep2_finish_o)
  );

  transaction_fsm transaction_fsm_i (
    .clock        (clock),
    .reset        (reset),
    .tok_recv_i   (tok_recv_i),
    .tok_addr_i   (tok_addr_i),
    .tok_endp_i   (tok_endp_i),
    .usb_addr_i   (usb_addr_i),
    .usb_pid_i    (usb_pid_i),
    .usb_recv_i   (usb_recv_i),
    .eop_recv_i   (eop_recv_i),
    .crc_error_i  (crc_error_i),
    .hsk_sent_i   (hsk_sent_i),
    .hsk_recv_i   (hsk_recv_i),
    .usb_sent_i   (usb_sent_i),
    .timeout_i    (timeout),
    .out_sel_i    (out_sel),
    .out_rdy_i    (out_rdy),
    .in_sel_i     (in_sel),
    .in_rdy_i     (in_rdy),
    .par_ok_i     (par_ok),
    .data_pid_i   (data_pid),
    .state_o      (state),
    .tok_hit_o    (tok_hit),
    .hsk_send_o   (hsk_send_o),
    .ulpi_tuser_o (ulpi_tuser_o),
    .mux_enable_o (mux_enable_o),
    .mux_select_o (mux_select_o)
  );

  bus_timeouts bus_timeouts_i (
    .clock      (clock),
    .reset      (reset),
    .state_i    (state),
    .tok_hit_i  (tok_hit),
    .usb_pid_i  (usb_pid_i),
    .usb_sent_i (usb_sent_i),
    .usb_busy_i (usb_busy_i),
    .hsk_recv_i (hsk_recv_i),
    .rx_event_i (rx_event_i),
    .timeout_o  (timeout)
  );

  assign timedout_o = timeout;

endmodule

//--- tb_usb_reference.svh
`ifndef TB_USB_REFERENCE_SVH
`define TB_USB_REFERENCE_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// DATAx PID carrying the given sequence bit
function automatic usb_txn_pkg::usb_pid_t datax(input logic seq);
  return seq ? usb_txn_pkg::PID_DATA1 : usb_txn_pkg::PID_DATA0;
endfunction

// Response to a token seen in idle, packed as {data sent, handshake sent, PID}
// A bulk endpoint only counts while configured and not halted
function automatic logic [5:0] expected_response(
  input usb_txn_pkg::usb_pid_t pid,
  input logic [3:0]            endp,
  input logic                  conf,
  input logic                  ep1_rdy,
  input logic                  ep1_halt,
  input logic                  ep2_rdy,
  input logic                  ep2_halt,
  input logic                  ep0_par,
  input logic                  ep2_par
);
  logic       ep0;
  logic       ep1_on;
  logic       ep2_on;
  logic [5:0] rsp;
  ep0    = (endp == 4'd0);
  ep1_on = conf && !ep1_halt && (endp == `BULK_OUT_EP);
  ep2_on = conf && !ep2_halt && (endp == `BULK_IN_EP);
  rsp    = '0;
  case (pid)
    usb_txn_pkg::PID_PING: begin
      if (ep0 || (ep1_on && ep1_rdy)) begin
        rsp = {2'b01, usb_txn_pkg::PID_ACK};
      end else if (ep1_on) begin
        rsp = {2'b01, usb_txn_pkg::PID_NAK};
      end else begin
        rsp = {2'b01, usb_txn_pkg::PID_STALL};
      end
    end
    usb_txn_pkg::PID_IN: begin
      if (ep0) begin
        rsp = {2'b10, datax(ep0_par)};
      end else if (ep2_on && ep2_rdy) begin
        rsp = {2'b10, datax(ep2_par)};
      end else if (ep2_on) begin
        rsp = {2'b01, usb_txn_pkg::PID_NAK};
      end
    end
    // OUT and SETUP answer only after the DATAx stage
    default: rsp = '0;
  endcase
  return rsp;
endfunction

`endif

//--- tb_usb_transaction.sv
`timescale 1ns/10ps
`include "usb_txn_macros.svh"

module tb_usb_transaction;

  localparam logic [6:0] DEV_ADDR = 7'd5;

  // Strobe codes
  localparam int S_SOP      = 0;
  localparam int S_HSK_SENT = 1;
  localparam int S_HSK_RECV = 2;
  localparam int S_USB_BUSY = 3;
  localparam int S_USB_SENT = 4;

  // Events to wait for
  localparam int W_HSK_LOW = 0;
  localparam int W_MUX_EN  = 1;
  localparam int W_FIN1    = 2;
  localparam int W_FIN2    = 3;
  localparam int W_TIMEOUT = 4;

  logic                   clock;
  logic                   reset;
  logic                   tok_recv_i;
  logic [6:0]             tok_addr_i;
  logic [3:0]             tok_endp_i;
  usb_txn_pkg::usb_pid_t  usb_pid_i;
  logic                   usb_recv_i;
  logic                   eop_recv_i;
  logic                   crc_error_i;
  logic [1:0]             rx_event_i;
  logic                   hsk_recv_i;
  logic                   hsk_sent_i;
  logic                   usb_busy_i;
  logic                   usb_sent_i;
  logic                   set_conf_i;
  logic                   clr_conf_i;
  logic [6:0]             usb_addr_i;
  logic                   ep0_parity_i;
  logic                   ep1_rx_rdy_i;
  logic                   ep1_parity_i;
  logic                   ep1_halted_i;
  logic                   ep2_tx_rdy_i;
  logic                   ep2_parity_i;
  logic                   ep2_halted_i;
  logic                   timedout_o;
  logic                   hsk_send_o;
  logic                   mux_enable_o;
  logic [2:0]             mux_select_o;
  usb_txn_pkg::usb_pid_t  ulpi_tuser_o;
  logic                   ep1_select_o;
  logic                   ep1_finish_o;
  logic                   ep2_select_o;
  logic                   ep2_finish_o;

  logic [15:0] lfsr_q;
  logic        cfg_on;
  int          checks;
  int          value_errors;
  int          wait_errors;
  string       test_name;

  `include "tb_usb_reference.svh"

  usb_transaction dut_i (
    .clock        (clock),
    .reset        (reset),
    .tok_recv_i   (tok_recv_i),
    .tok_addr_i   (tok_addr_i),
    .tok_endp_i   (tok_endp_i),
    .usb_pid_i    (usb_pid_i),
    .usb_recv_i   (usb_recv_i),
    .eop_recv_i   (eop_recv_i),
    .crc_error_i  (crc_error_i),
    .rx_event_i   (rx_event_i),
    .hsk_recv_i   (hsk_recv_i),
    .hsk_sent_i   (hsk_sent_i),
    .usb_busy_i   (usb_busy_i),
    .usb_sent_i   (usb_sent_i),
    .set_conf_i   (set_conf_i),
    .clr_conf_i   (clr_conf_i),
    .usb_addr_i   (usb_addr_i),
    .ep0_parity_i (ep0_parity_i),
    .ep1_rx_rdy_i (ep1_rx_rdy_i),
    .ep1_parity_i (ep1_parity_i),
    .ep1_halted_i (ep1_halted_i),
    .ep2_tx_rdy_i (ep2_tx_rdy_i),
    .ep2_parity_i (ep2_parity_i),
    .ep2_halted_i (ep2_halted_i),
    .timedout_o   (timedout_o),
    .hsk_send_o   (hsk_send_o),
    .mux_enable_o (mux_enable_o),
    .mux_select_o (mux_select_o),
    .ulpi_tuser_o (ulpi_tuser_o),
    .ep1_select_o (ep1_select_o),
    .ep1_finish_o (ep1_finish_o),
    .ep2_select_o (ep2_select_o),
    .ep2_finish_o (ep2_finish_o)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic compare(input string what, input logic [7:0] expected,
                         input logic [7:0] actual);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic random_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v[i] = lfsr_q[0];
    end
  endtask

  task automatic drive_strobe(input int which, input logic level);
    case (which)
      S_SOP:      rx_event_i <= level ? `RX_EVENT_SOP : 2'b00;
      S_HSK_SENT: hsk_sent_i <= level;
      S_HSK_RECV: hsk_recv_i <= level;
      S_USB_BUSY: usb_busy_i <= level;
      default:    usb_sent_i <= level;
    endcase
  endtask

  // One-cycle pulse on a strobe input
  task automatic strobe(input int which);
    @(posedge clock);
    drive_strobe(which, 1'b1);
    @(posedge clock);
    drive_strobe(which, 1'b0);
  endtask

  task automatic wait_for(input int which, input int limit, input string what);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < limit) begin
      @(negedge clock);
      n++;
      case (which)
        W_HSK_LOW: seen = !hsk_send_o;
        W_MUX_EN:  seen = mux_enable_o;
        W_FIN1:    seen = ep1_finish_o;
        W_FIN2:    seen = ep2_finish_o;
        default:   seen = timedout_o;
      endcase
    end
    if (!seen) begin
      wait_errors++;
      $display("%s: %s did not happen within %0d cycles", test_name, what, limit);
    end
  endtask

  // Levels and a configuration strobe, sampled together at one edge
  task automatic configure(input logic conf, input logic r1, input logic h1, input logic p1,
                           input logic r2, input logic h2, input logic p2);
    @(posedge clock);
    cfg_on = conf;
    ep1_rx_rdy_i <= r1;
    ep1_halted_i <= h1;
    ep1_parity_i <= p1;
    ep2_tx_rdy_i <= r2;
    ep2_halted_i <= h2;
    ep2_parity_i <= p2;
    set_conf_i   <= conf;
    clr_conf_i   <= !conf;
    @(posedge clock);
    set_conf_i <= 1'b0;
    clr_conf_i <= 1'b0;
  endtask

  // Returns just after the edge that sampled the token
  task automatic send_token(input usb_txn_pkg::usb_pid_t pid, input logic [3:0] endp,
                            input logic [6:0] addr);
    @(posedge clock);
    usb_pid_i  <= pid;
    tok_endp_i <= endp;
    tok_addr_i <= addr;
    tok_recv_i <= 1'b1;
    @(posedge clock);
    tok_recv_i <= 1'b0;
    @(negedge clock);
  endtask

  task automatic send_data(input usb_txn_pkg::usb_pid_t pid);
    strobe(S_SOP);
    @(posedge clock);
    usb_pid_i  <= pid;
    usb_recv_i <= 1'b1;
    @(posedge clock);
    usb_recv_i <= 1'b0;
    @(negedge clock);
  endtask

  task automatic check_token(input usb_txn_pkg::usb_pid_t pid, input logic [3:0] endp);
    logic [5:0] exp;
    send_token(pid, endp, DEV_ADDR);
    exp = expected_response(pid, endp, cfg_on, ep1_rx_rdy_i, ep1_halted_i, ep2_tx_rdy_i,
                            ep2_halted_i, ep0_parity_i, ep2_parity_i);
    compare("hsk_send_o", 8'(exp[4]), 8'(hsk_send_o));
    if (exp[5] || exp[4]) begin
      compare("ulpi_tuser_o", 8'(exp[3:0]), 8'(ulpi_tuser_o));
    end
  endtask

  // Encoder starts the handshake packet and reports it sent
  task automatic complete_handshake();
    strobe(S_USB_BUSY);
    strobe(S_HSK_SENT);
    wait_for(W_HSK_LOW, 4, "hsk_send_o release after hsk_sent_i");
  endtask

  task automatic expect_no_handshake(input int cycles);
    repeat (cycles) begin
      @(negedge clock);
      compare("hsk_send_o quiet", 8'd0, 8'(hsk_send_o));
    end
  endtask

  initial begin
    logic [7:0] r;
    logic [3:0] endp;
    lfsr_q       = 16'd24715;
    cfg_on       = 1'b0;
    checks       = 0;
    value_errors = 0;
    wait_errors  = 0;
    test_name    = "reset";
    reset        <= 1'b1;
    tok_recv_i   <= 1'b0;
    tok_addr_i   <= DEV_ADDR;
    tok_endp_i   <= 4'd0;
    usb_pid_i    <= usb_txn_pkg::PID_OUT;
    usb_recv_i   <= 1'b0;
    eop_recv_i   <= 1'b0;
    crc_error_i  <= 1'b0;
    rx_event_i   <= 2'b00;
    hsk_recv_i   <= 1'b0;
    hsk_sent_i   <= 1'b0;
    usb_busy_i   <= 1'b0;
    usb_sent_i   <= 1'b0;
    set_conf_i   <= 1'b0;
    clr_conf_i   <= 1'b0;
    usb_addr_i   <= DEV_ADDR;
    ep0_parity_i <= 1'b0;
    ep1_rx_rdy_i <= 1'b0;
    ep1_parity_i <= 1'b0;
    ep1_halted_i <= 1'b0;
    ep2_tx_rdy_i <= 1'b0;
    ep2_parity_i <= 1'b0;
    ep2_halted_i <= 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    compare("hsk_send_o", 8'd0, 8'(hsk_send_o));
    compare("mux_enable_o", 8'd0, 8'(mux_enable_o));
    compare("timedout_o", 8'd0, 8'(timedout_o));
    compare("selects", 8'd0, 8'({ep1_select_o, ep2_select_o}));
    compare("finishes", 8'd0, 8'({ep1_finish_o, ep2_finish_o}));

    test_name = "ping_random";
    for (int t = 0; t < 40; t++) begin
      random_bits(7, r);
      configure(r[0], r[1], r[2], r[3], r[4], r[5], r[6]);
      random_bits(2, r);
      endp = (r[1:0] == 2'd3) ? `BULK_OUT_EP : {2'b00, r[1:0]};
      check_token(usb_txn_pkg::PID_PING, endp);
      complete_handshake();
    end

    test_name = "out_ep1";
    random_bits(1, r);
    configure(1'b1, 1'b1, 1'b0, r[0], 1'b0, 1'b0, 1'b0);
    check_token(usb_txn_pkg::PID_OUT, `BULK_OUT_EP);
    compare("ep1_select_o", 8'd1, 8'(ep1_select_o));
    send_data(datax(ep1_parity_i));
    compare("hsk_send_o", 8'd1, 8'(hsk_send_o));
    compare("ulpi_tuser_o", 8'(usb_txn_pkg::PID_ACK), 8'(ulpi_tuser_o));
    strobe(S_HSK_SENT);
    wait_for(W_FIN1, 3, "ep1_finish_o after hsk_sent_i");
    @(negedge clock);
    compare("ep1_finish_o width", 8'd0, 8'(ep1_finish_o));
    // Wrong sequence bit, the packet is dropped without a handshake
    check_token(usb_txn_pkg::PID_OUT, `BULK_OUT_EP);
    send_data(datax(!ep1_parity_i));
    compare("hsk_send_o", 8'd0, 8'(hsk_send_o));
    expect_no_handshake(4);
    check_token(usb_txn_pkg::PID_PING, `BULK_OUT_EP);
    complete_handshake();

    test_name = "in_ep2";
    random_bits(1, r);
    configure(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, r[0]);
    check_token(usb_txn_pkg::PID_IN, `BULK_IN_EP);
    compare("ep2_select_o", 8'd1, 8'(ep2_select_o));
    wait_for(W_MUX_EN, 3, "mux_enable_o after IN");
    compare("mux_select_o", 8'd2, 8'(mux_select_o));
    strobe(S_USB_BUSY);
    strobe(S_USB_SENT);
    strobe(S_HSK_RECV);
    wait_for(W_FIN2, 3, "ep2_finish_o after hsk_recv_i");
    @(negedge clock);
    compare("ep2_finish_o width", 8'd0, 8'(ep2_finish_o));
    configure(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, r[0]);
    check_token(usb_txn_pkg::PID_IN, `BULK_IN_EP);
    complete_handshake();

    test_name = "td_timeout";
    configure(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    check_token(usb_txn_pkg::PID_OUT, `BULK_OUT_EP);
    wait_for(W_TIMEOUT, `TD_TIMEOUT + 4, "timedout_o after OUT without data");
    @(negedge clock);
    compare("timedout_o width", 8'd0, 8'(timedout_o));
    check_token(usb_txn_pkg::PID_PING, 4'd0);
    complete_handshake();

    test_name = "config_addr";
    configure(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    check_token(usb_txn_pkg::PID_PING, `BULK_OUT_EP);
    complete_handshake();
    configure(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    check_token(usb_txn_pkg::PID_PING, `BULK_OUT_EP);
    complete_handshake();
    configure(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    send_token(usb_txn_pkg::PID_PING, `BULK_OUT_EP, 7'd6);
    compare("hsk_send_o", 8'd0, 8'(hsk_send_o));
    compare("ep1_select_o", 8'd0, 8'(ep1_select_o));
    expect_no_handshake(3);
    check_token(usb_txn_pkg::PID_PING, `BULK_OUT_EP);
    complete_handshake();

    $display("Checks %0d, value errors %0d, wait timeouts %0d",
             checks, value_errors, wait_errors);
    if (value_errors == 0 && wait_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+.
usb_txn_pkg.sv
endpoint_ctrl.sv
transaction_fsm.sv
response_timer.sv
bus_timeouts.sv
usb_transaction.sv
tb_usb_transaction.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the transaction-layer testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_usb_transaction -f build.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  exit 1
fi
exit 0
